// File: cpuFrontPkg.sv
package cpuFrontPkg;

    // Word, address and immediate width
    localparam int dataWidth = 16;

    // Queue sizing, depth must be a power of two
    localparam int queueDepth = 4;
    localparam int queuePtrWidth = $clog2(queueDepth);
    localparam int queueCountWidth = $clog2(queueDepth + 1);

    // Bit positions in the one-hot unit enable
    localparam int fuAlu0Bit = 0;
    localparam int fuAlu1Bit = 1;
    localparam int fuComplexBit = 2;
    localparam int fuMemoryBit = 3;
    localparam int fuBranchBit = 4;

    // Writeback source codes, 3 is reserved
    localparam logic [1:0] wbAlu0 = 2'd0;
    localparam logic [1:0] wbAlu1 = 2'd1;
    localparam logic [1:0] wbPcPlusOne = 2'd2;

    // One instruction word seen through its two field layouts
    typedef union packed {
        struct packed {
            logic [3:0] major;
            logic [3:0] regA;
            logic [3:0] minor;
            logic [3:0] regB;
        } regForm;
        struct packed {
            logic [3:0] major;
            logic [1:0] regAUpper;
            logic [9:0] immField;
        } immForm;
    } instrWord_u;

endpackage

// File: instructionDecoder.sv
`timescale 1ns/1ns

module instructionDecoder
    import cpuFrontPkg::*;
(
    input  instrWord_u           instruction,
    input  logic                 instructionValid,
    output logic                 tagRequest,
    output logic [4:0]           unitEnable,
    output logic [1:0]           writebackSource,
    output logic [3:0]           minorOpcode,
    output logic                 immediateEn,
    output logic                 upperImmediateEn,
    output logic [dataWidth-1:0] immediate,
    output logic                 regAReadEn,
    output logic                 regAWriteEn,
    output logic [3:0]           regAAddr,
    output logic                 regBReadEn,
    output logic [3:0]           regBAddr,
    output logic                 branchStall,
    output logic                 decodeValid
);

    logic [3:0]           major;
    logic [7:0]           lowByte;
    logic                 jumpAndLink;
    logic [3:0]           selRegA;
    logic [dataWidth-1:0] selImmediate;

    assign major = instruction.regForm.major;
    assign lowByte = {instruction.regForm.minor, instruction.regForm.regB};
    assign jumpAndLink = (major == 4'd8) || (major == 4'd9);

    // Link register is 15, upper forms only name every fourth register
    always_comb begin
        if (jumpAndLink) begin
            selRegA = 4'hf;
        end else if (major[3] && major[0]) begin
            selRegA = {instruction.immForm.regAUpper, 2'b00};
        end else begin
            selRegA = instruction.regForm.regA;
        end
    end

    always_comb begin
        case (major[1:0])
            2'd0: selImmediate = {{(dataWidth - 8){1'b0}}, lowByte};
            2'd1: selImmediate = {{(dataWidth - 10){1'b0}}, instruction.immForm.immField};
            2'd2: selImmediate = {lowByte, {(dataWidth - 8){1'b0}}};
            default: selImmediate = {{(dataWidth - 10){1'b1}}, instruction.immForm.immField};
        endcase
    end

    always_comb begin
        tagRequest = 1'b0;
        unitEnable = '0;
        writebackSource = wbAlu0;
        immediateEn = 1'b0;
        upperImmediateEn = 1'b0;
        regAReadEn = 1'b0;
        regAWriteEn = 1'b0;
        regBReadEn = 1'b0;
        decodeValid = instructionValid;
        case (major)
            4'd0, 4'd1: begin
                unitEnable[major[0] ? fuAlu1Bit : fuAlu0Bit] = 1'b1;
                writebackSource = major[0] ? wbAlu1 : wbAlu0;
                regAReadEn = 1'b1;
                regAWriteEn = 1'b1;
                regBReadEn = 1'b1;
            end
            4'd2, 4'd3: begin
                unitEnable[major[0] ? fuMemoryBit : fuComplexBit] = 1'b1;
                tagRequest = 1'b1;
                regAReadEn = 1'b1;
                regBReadEn = 1'b1;
            end
            4'd8, 4'd9, 4'd10, 4'd11: begin
                unitEnable[fuBranchBit] = 1'b1;
                // Odd opcodes take the immediate, 8 and 9 also link
                immediateEn = major[0];
                regBReadEn = (major == 4'd8);
                if (jumpAndLink) begin
                    writebackSource = wbPcPlusOne;
                    regAWriteEn = 1'b1;
                end
            end
            4'd12, 4'd13, 4'd14, 4'd15: begin
                immediateEn = 1'b1;
                upperImmediateEn = (major == 4'd14);
                regAReadEn = 1'b1;
                regAWriteEn = 1'b1;
            end
            default: decodeValid = 1'b0;
        endcase
        if (!decodeValid) begin
            tagRequest = 1'b0;
            unitEnable = '0;
            writebackSource = wbAlu0;
            immediateEn = 1'b0;
            upperImmediateEn = 1'b0;
            regAReadEn = 1'b0;
            regAWriteEn = 1'b0;
            regBReadEn = 1'b0;
        end
    end

    assign regAAddr = decodeValid ? selRegA : 4'd0;
    assign regBAddr = decodeValid ? instruction.regForm.regB : 4'd0;
    assign minorOpcode = decodeValid ? instruction.regForm.minor : 4'd0;
    assign immediate = decodeValid ? selImmediate : '0;
    assign branchStall = decodeValid && (major[3:2] == 2'b10) && (selRegA != 4'd0);

endmodule

// File: instrFetch.sv
`timescale 1ns/1ns

module instrFetch
    import cpuFrontPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 memAck,
    input  logic [dataWidth-1:0] memData,
    input  logic                 queueFull,
    input  logic                 fetchHold,
    input  logic                 branchResolve,
    input  logic [dataWidth-1:0] branchTarget,
    output logic                 memReq,
    output logic [dataWidth-1:0] memAddr,
    output logic                 pushEn,
    output logic [dataWidth-1:0] pushWord,
    output logic [dataWidth-1:0] pushPc
);

    logic [dataWidth-1:0] pc;
    logic                 cancelled;
    logic                 startReq;

    // New request only once the last ack is gone and the last push has landed
    assign startReq = !memReq && !memAck && !pushEn && !queueFull && !fetchHold
                      && !branchResolve;

    // memReq doubles as the state: low is idle, high is waiting for ack
    always_ff @(posedge clk) begin
        if (reset) begin
            memReq <= 1'b0;
            memAddr <= '0;
            pc <= '0;
            pushEn <= 1'b0;
            cancelled <= 1'b0;
        end else begin
            pushEn <= 1'b0;
            if (startReq) begin
                memReq <= 1'b1;
                memAddr <= pc;
                cancelled <= 1'b0;
            end else if (memReq && memAck) begin
                memReq <= 1'b0;
                pushEn <= !cancelled && !branchResolve;
                // A cancelled word already had its pc replaced by the target
                if (!cancelled) begin
                    pc <= pc + 1'b1;
                end
            end else if (memReq && branchResolve) begin
                cancelled <= 1'b1;
            end
            // Redirect wins over the increment
            if (branchResolve) begin
                pc <= branchTarget;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memReq && memAck) begin
            pushWord <= memData;
            pushPc <= memAddr;
        end
    end

endmodule

// File: instrQueue.sv
`timescale 1ns/1ns

module instrQueue
    import cpuFrontPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pushEn,
    input  logic [dataWidth-1:0] pushWord,
    input  logic [dataWidth-1:0] pushPc,
    input  logic                 popEn,
    input  logic                 flush,
    output logic                 queueFull,
    output logic                 queueEmpty,
    output logic [dataWidth-1:0] headWord,
    output logic [dataWidth-1:0] headPc
);

    logic [dataWidth-1:0]       wordMem [queueDepth];
    logic [dataWidth-1:0]       pcMem [queueDepth];
    logic [queuePtrWidth-1:0]   rdPtr;
    logic [queuePtrWidth-1:0]   wrPtr;
    logic [queueCountWidth-1:0] count;
    logic                       doPush;
    logic                       doPop;

    assign queueFull = (count == queueCountWidth'(queueDepth));
    assign queueEmpty = (count == '0);
    assign doPush = pushEn && !queueFull;
    assign doPop = popEn && !queueEmpty;

    // Head is read straight from storage
    assign headWord = wordMem[rdPtr];
    assign headPc = pcMem[rdPtr];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            // Pointers wrap naturally at a power-of-two depth
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush && !flush) begin
            wordMem[wrPtr] <= pushWord;
            pcMem[wrPtr] <= pushPc;
        end
    end

endmodule

// File: decodeDispatch.sv
`timescale 1ns/1ns

module decodeDispatch
    import cpuFrontPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 queueEmpty,
    input  logic [dataWidth-1:0] headWord,
    input  logic [dataWidth-1:0] headPc,
    input  logic                 issueAck,
    input  logic                 branchResolve,
    output logic                 popEn,
    output logic                 fetchHold,
    output logic                 issueReq,
    output logic [dataWidth-1:0] issuePc,
    output logic                 tagRequest,
    output logic [4:0]           unitEnable,
    output logic [1:0]           writebackSource,
    output logic [3:0]           minorOpcode,
    output logic                 immediateEn,
    output logic                 upperImmediateEn,
    output logic [dataWidth-1:0] immediate,
    output logic                 regAReadEn,
    output logic                 regAWriteEn,
    output logic [3:0]           regAAddr,
    output logic                 regBReadEn,
    output logic [3:0]           regBAddr
);

    logic                 decTagRequest;
    logic [4:0]           decUnitEnable;
    logic [1:0]           decWritebackSource;
    logic [3:0]           decMinorOpcode;
    logic                 decImmediateEn;
    logic                 decUpperImmediateEn;
    logic [dataWidth-1:0] decImmediate;
    logic                 decRegAReadEn;
    logic                 decRegAWriteEn;
    logic [3:0]           decRegAAddr;
    logic                 decRegBReadEn;
    logic [3:0]           decRegBAddr;
    logic                 decBranchStall;
    logic                 decValid;
    logic                 accept;

    instructionDecoder i_decoder (
        .instruction      (headWord),
        .instructionValid (!queueEmpty),
        .tagRequest       (decTagRequest),
        .unitEnable       (decUnitEnable),
        .writebackSource  (decWritebackSource),
        .minorOpcode      (decMinorOpcode),
        .immediateEn      (decImmediateEn),
        .upperImmediateEn (decUpperImmediateEn),
        .immediate        (decImmediate),
        .regAReadEn       (decRegAReadEn),
        .regAWriteEn      (decRegAWriteEn),
        .regAAddr         (decRegAAddr),
        .regBReadEn       (decRegBReadEn),
        .regBAddr         (decRegBAddr),
        .branchStall      (decBranchStall),
        .decodeValid      (decValid)
    );

    // Idle means no request out and the previous ack already gone
    assign popEn = !queueEmpty && !issueReq && !issueAck && !fetchHold && !branchResolve;
    // Invalid words are popped but never accepted
    assign accept = popEn && decValid;

    always_ff @(posedge clk) begin
        if (reset) begin
            issueReq <= 1'b0;
            fetchHold <= 1'b0;
        end else begin
            if (accept) begin
                issueReq <= 1'b1;
            end else if (issueReq && issueAck) begin
                issueReq <= 1'b0;
            end
            if (branchResolve) begin
                fetchHold <= 1'b0;
            end else if (accept && decBranchStall) begin
                fetchHold <= 1'b1;
            end
        end
    end

    // Issue fields held stable for the whole handshake
    always_ff @(posedge clk) begin
        if (accept) begin
            issuePc <= headPc;
            tagRequest <= decTagRequest;
            unitEnable <= decUnitEnable;
            writebackSource <= decWritebackSource;
            minorOpcode <= decMinorOpcode;
            immediateEn <= decImmediateEn;
            upperImmediateEn <= decUpperImmediateEn;
            immediate <= decImmediate;
            regAReadEn <= decRegAReadEn;
            regAWriteEn <= decRegAWriteEn;
            regAAddr <= decRegAAddr;
            regBReadEn <= decRegBReadEn;
            regBAddr <= decRegBAddr;
        end
    end

endmodule

// File: decodeFrontEnd.sv
`timescale 1ns/1ns

module decodeFrontEnd
    import cpuFrontPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    output logic                 memReq,
    output logic [dataWidth-1:0] memAddr,
    input  logic [dataWidth-1:0] memData,
    input  logic                 memAck,
    output logic                 issueReq,
    input  logic                 issueAck,
    output logic [dataWidth-1:0] issuePc,
    output logic                 tagRequest,
    output logic [4:0]           unitEnable,
    output logic [1:0]           writebackSource,
    output logic [3:0]           minorOpcode,
    output logic                 immediateEn,
    output logic                 upperImmediateEn,
    output logic [dataWidth-1:0] immediate,
    output logic                 regAReadEn,
    output logic                 regAWriteEn,
    output logic [3:0]           regAAddr,
    output logic                 regBReadEn,
    output logic [3:0]           regBAddr,
    input  logic                 branchResolve,
    input  logic [dataWidth-1:0] branchTarget
);

    // Fetch to queue
    logic                 pushEn;
    logic [dataWidth-1:0] pushWord;
    logic [dataWidth-1:0] pushPc;
    logic                 queueFull;

    // Queue to dispatch
    logic                 queueEmpty;
    logic [dataWidth-1:0] headWord;
    logic [dataWidth-1:0] headPc;
    logic                 popEn;
    logic                 fetchHold;

    instrFetch i_fetch (.*);

    // A resolved branch flushes everything queued behind it
    instrQueue i_queue (
        .*,
        .flush (branchResolve)
    );

    decodeDispatch i_dispatch (.*);

endmodule

// File: decodeFrontEndTb.sv
`timescale 1ns/1ns

module decodeFrontEndTb
    import cpuFrontPkg::*;
;

    localparam int clkPeriod = 40;
    localparam int testIssues = 200;
    localparam int watchdogIssues = 400;
    localparam int cyclesPerIssue = 60;
    localparam logic [dataWidth-1:0] resolveAddr = 16'd32;

    logic                 clk;
    logic                 reset;
    logic                 memReq;
    logic [dataWidth-1:0] memAddr;
    logic [dataWidth-1:0] memData;
    logic                 memAck;
    logic                 issueReq;
    logic                 issueAck;
    logic [dataWidth-1:0] issuePc;
    logic                 tagRequest;
    logic [4:0]           unitEnable;
    logic [1:0]           writebackSource;
    logic [3:0]           minorOpcode;
    logic                 immediateEn;
    logic                 upperImmediateEn;
    logic [dataWidth-1:0] immediate;
    logic                 regAReadEn;
    logic                 regAWriteEn;
    logic [3:0]           regAAddr;
    logic                 regBReadEn;
    logic [3:0]           regBAddr;
    logic                 branchResolve;
    logic [dataWidth-1:0] branchTarget;

    logic [dataWidth-1:0] mem [0:65535];
    logic [31:0]          lcgState;
    int                   issueCount;
    int                   resolveCount;

    // Reference model state
    logic [41:0]          expDecode;
    logic [40:0]          expFields;
    logic [40:0]          issueFields;
    logic [56:0]          issueBus;
    logic                 issueOpValid;
    logic [dataWidth-1:0] expectPc;
    logic [dataWidth-1:0] resolveTarget;
    logic                 issueReqPrev;
    logic                 memReqPrev;
    logic                 stallActive;
    logic                 retarget;

    decodeFrontEnd i_dut (.*);

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic logic [15:0] drawRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[31:16];
    endfunction

    function automatic logic isValidOp(input logic [3:0] op);
        return !(op >= 4'd4 && op <= 4'd7);
    endfunction

    // First address at or after a that holds a valid opcode
    function automatic logic [dataWidth-1:0] nextValidFrom(input logic [dataWidth-1:0] a);
        logic [dataWidth-1:0] p;
        logic                 found;
        p = a;
        found = 1'b0;
        for (int i = 0; i < 64; i++) begin
            if (!found) begin
                if (isValidOp(mem[p][15:12])) begin
                    found = 1'b1;
                end else begin
                    p = p + 16'd1;
                end
            end
        end
        return p;
    endfunction

    // Stall flag in bit 41 above the fields in issue port order
    function automatic logic [41:0] refDecode(input logic [15:0] w);
        logic [3:0]  op;
        logic        valid;
        logic        tag;
        logic [4:0]  unit;
        logic [1:0]  wb;
        logic        immEn;
        logic        upImm;
        logic        aRd;
        logic        aWr;
        logic        bRd;
        logic [3:0]  aAddr;
        logic [15:0] imm;
        logic        stall;
        op = w[15:12];
        valid = 1'b1;
        tag = 1'b0;
        unit = 5'b00000;
        wb = 2'd0;
        immEn = 1'b0;
        upImm = 1'b0;
        aRd = 1'b0;
        aWr = 1'b0;
        bRd = 1'b0;
        case (op)
            4'd0: begin unit = 5'b00001; aRd = 1'b1; aWr = 1'b1; bRd = 1'b1; end
            4'd1: begin unit = 5'b00010; wb = 2'd1; aRd = 1'b1; aWr = 1'b1; bRd = 1'b1; end
            4'd2: begin unit = 5'b00100; tag = 1'b1; aRd = 1'b1; bRd = 1'b1; end
            4'd3: begin unit = 5'b01000; tag = 1'b1; aRd = 1'b1; bRd = 1'b1; end
            4'd8: begin unit = 5'b10000; wb = 2'd2; aWr = 1'b1; bRd = 1'b1; end
            4'd9: begin unit = 5'b10000; wb = 2'd2; aWr = 1'b1; immEn = 1'b1; end
            4'd10: unit = 5'b10000;
            4'd11: begin unit = 5'b10000; immEn = 1'b1; end
            4'd14: begin immEn = 1'b1; upImm = 1'b1; aRd = 1'b1; aWr = 1'b1; end
            4'd12, 4'd13, 4'd15: begin immEn = 1'b1; aRd = 1'b1; aWr = 1'b1; end
            default: valid = 1'b0;
        endcase
        if (op == 4'd8 || op == 4'd9) begin
            aAddr = 4'd15;
        end else if (w[15] && w[12]) begin
            aAddr = {w[11:10], 2'b00};
        end else begin
            aAddr = w[11:8];
        end
        case (w[13:12])
            2'd0: imm = {8'h00, w[7:0]};
            2'd1: imm = {6'h00, w[9:0]};
            2'd2: imm = {w[7:0], 8'h00};
            default: imm = {6'h3f, w[9:0]};
        endcase
        stall = (op >= 4'd8 && op <= 4'd11) && (aAddr != 4'd0);
        if (!valid) begin
            return '0;
        end
        return {stall, tag, unit, wb, w[7:4], immEn, upImm, imm, aRd, aWr, aAddr, bRd, w[3:0]};
    endfunction

    assign expDecode = refDecode(mem[issuePc]);
    assign expFields = expDecode[40:0];
    assign issueOpValid = isValidOp(mem[issuePc][15:12]);
    assign issueFields = {tagRequest, unitEnable, writebackSource, minorOpcode, immediateEn,
                          upperImmediateEn, immediate, regAReadEn, regAWriteEn, regAAddr,
                          regBReadEn, regBAddr};
    assign issueBus = {issuePc, issueFields};

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Program order, stall window and redirect tracking
    always @(posedge clk) begin
        if (reset) begin
            expectPc <= nextValidFrom(16'd0);
            issueReqPrev <= 1'b0;
            memReqPrev <= 1'b0;
            stallActive <= 1'b0;
            retarget <= 1'b0;
            resolveTarget <= '0;
        end else begin
            issueReqPrev <= issueReq;
            memReqPrev <= memReq;
            if (memReq && !memReqPrev) begin
                retarget <= 1'b0;
            end
            if (branchResolve) begin
                expectPc <= nextValidFrom(branchTarget);
                stallActive <= 1'b0;
                retarget <= 1'b1;
                resolveTarget <= branchTarget;
            end else if (issueReq && !issueReqPrev) begin
                expectPc <= nextValidFrom(expectPc + 16'd1);
                if (expDecode[41]) begin
                    stallActive <= 1'b1;
                end
            end
        end
    end

    fieldCheck: assert property (@(posedge clk) disable iff (reset)
        $rose(issueReq) |-> issueFields == expFields)
        else failRun($sformatf("Error: issue fields at issuePc %h are %h, expected %h",
                               $sampled(issuePc), $sampled(issueFields), $sampled(expFields)));

    orderCheck: assert property (@(posedge clk) disable iff (reset)
        $rose(issueReq) |-> issuePc == expectPc)
        else failRun($sformatf("Error: issuePc is %h, expected %h",
                               $sampled(issuePc), $sampled(expectPc)));

    invalidCheck: assert property (@(posedge clk) disable iff (reset)
        $rose(issueReq) |-> issueOpValid)
        else failRun($sformatf("Error: word %h with an invalid opcode issued at issuePc %h",
                               mem[$sampled(issuePc)], $sampled(issuePc)));

    memHoldCheck: assert property (@(posedge clk) disable iff (reset)
        memReq && !memAck |=> memReq)
        else failRun("memReq was dropped before memAck arrived");

    memStartCheck: assert property (@(posedge clk) disable iff (reset)
        $rose(memReq) |-> !$past(memAck))
        else failRun("memReq rose while memAck was still high");

    memAddrCheck: assert property (@(posedge clk) disable iff (reset)
        memReq && $past(memReq) |-> $stable(memAddr))
        else failRun("memAddr changed while memReq was high");

    issueHoldCheck: assert property (@(posedge clk) disable iff (reset)
        issueReq && !issueAck |=> issueReq)
        else failRun("issueReq was dropped before issueAck arrived");

    issueStartCheck: assert property (@(posedge clk) disable iff (reset)
        $rose(issueReq) |-> !$past(issueAck))
        else failRun("issueReq rose while issueAck was still high");

    issueStableCheck: assert property (@(posedge clk) disable iff (reset)
        issueReq && $past(issueReq) |-> $stable(issueBus))
        else failRun("Issue fields changed while issueReq was high");

    stallCheck: assert property (@(posedge clk) disable iff (reset)
        stallActive |-> !$rose(memReq) && !$rose(issueReq))
        else failRun("Fetch or issue went on while a stalling branch was unresolved");

    redirectCheck: assert property (@(posedge clk) disable iff (reset)
        retarget && $rose(memReq) |-> memAddr == resolveTarget)
        else failRun($sformatf("Error: memAddr after resolve is %h, expected %h",
                               $sampled(memAddr), $sampled(resolveTarget)));

    // Memory with random answer delays and ack hold times
    initial begin
        logic [15:0] r;
        logic [15:0] delay;
        forever begin
            @(negedge clk);
            if (memReq && !memAck) begin
                r = drawRandom();
                // Long answers let a resolve land on a request in flight
                if (r % 8 == 0) begin
                    delay = 5 + (r >> 4) % 4;
                end else begin
                    delay = r % 4;
                end
                repeat (delay) @(negedge clk);
                memData = mem[memAddr];
                memAck = 1'b1;
                do @(negedge clk); while (memReq);
                r = drawRandom();
                repeat (r % 3) @(negedge clk);
                memAck = 1'b0;
            end
        end
    end

    // Issue stage with occasional long acks and branch resolves
    initial begin
        logic [15:0] r;
        logic [15:0] delay;
        logic        stall;
        forever begin
            @(negedge clk);
            if (issueReq && !issueAck) begin
                stall = expDecode[41];
                r = drawRandom();
                if (r % 4 == 0) begin
                    delay = 12 + (r >> 4) % 16;
                end else begin
                    delay = (r >> 4) % 3;
                end
                repeat (delay) @(negedge clk);
                issueAck = 1'b1;
                do @(negedge clk); while (issueReq);
                r = drawRandom();
                repeat (r % 3) @(negedge clk);
                issueAck = 1'b0;
                issueCount++;
                if (stall) begin
                    repeat (3) @(negedge clk);
                    branchTarget = resolveAddr;
                    branchResolve = 1'b1;
                    @(negedge clk);
                    branchResolve = 1'b0;
                    resolveCount++;
                end
            end
        end
    end

    initial begin
        #(watchdogIssues * cyclesPerIssue * clkPeriod);
        failRun("Timeout: the front end stopped issuing instructions");
    end

    initial begin
        reset = 1'b1;
        memAck = 1'b0;
        memData = '0;
        issueAck = 1'b0;
        branchResolve = 1'b0;
        branchTarget = '0;
        issueCount = 0;
        resolveCount = 0;
        lcgState = 32'd75;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = drawRandom() ^ 16'(i);
        end
        // Fixed program head with the stalling jump and link at 5
        mem[0] = 16'h0312;
        mem[1] = 16'hE5A7;
        mem[2] = 16'h4000;
        mem[3] = 16'hA012;
        mem[4] = 16'hD9C3;
        mem[5] = 16'h8034;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        wait (issueCount >= testIssues);
        repeat (4) @(negedge clk);
        if (resolveCount == 0) begin
            failRun("No stalling branch was resolved during the run");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: flist.f
cpuFrontPkg.sv
instructionDecoder.sv
instrFetch.sv
instrQueue.sv
decodeDispatch.sv
decodeFrontEnd.sv
decodeFrontEndTb.sv

// File: run.sh
#!/bin/bash
# Build and run with Verilator, verdict from the simulation log
verilator --binary --timing --assert -Wno-fatal --top-module decodeFrontEndTb \
    -f flist.f -o simv > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL: no verdict in log"; exit 1; }
echo "PASS"
